// ==== src/video_pkg.sv ====
`default_nettype none

package video_pkg;

   localparam int meta_width     = 16;
   localparam int lut_addr_width = 10;

   // pixel beat type carried alongside every stream word.
   typedef enum logic [2:0] {
      dt_frame_start = 3'd0,
      dt_line_start  = 3'd1,
      dt_pixel       = 3'd2,
      dt_line_end    = 3'd3,
      dt_frame_end   = 3'd4
   } dtype_e;

   typedef enum logic [15:0] {
      term_lookup_map    = 16'h0001,
      term_chroma_offset = 16'h0002
   } term_e;

   localparam logic [15:0] status_ok       = 16'h0000;
   localparam logic [15:0] status_bad_term = 16'hffff; // no terminal answered.

endpackage

`default_nettype wire

// ==== src/di_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface di_bus_if #(
   parameter int di_data_width = 16
);

   logic                     sel;
   logic [31:0]              reg_addr;
   logic                     read_mode;
   logic                     read_req;
   logic                     write_mode;
   logic                     write;
   logic [di_data_width-1:0] datai;

   logic                     read_rdy;
   logic [di_data_width-1:0] datao;
   logic                     write_rdy;
   logic [15:0]              status;

   modport host (
      output sel, reg_addr, read_mode, read_req, write_mode, write, datai,
      input  read_rdy, datao, write_rdy, status
   );

   modport term (
      input  sel, reg_addr, read_mode, read_req, write_mode, write, datai,
      output read_rdy, datao, write_rdy, status
   );

endinterface

`default_nettype wire

// ==== src/pixel_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface pixel_if #(
   parameter int pixel_width = 8
);
   import video_pkg::*;

   logic                          dv;
   dtype_e                        dtype;
   logic        [pixel_width-1:0] y;
   logic signed [pixel_width-1:0] u;
   logic signed [pixel_width-1:0] v;
   logic        [meta_width-1:0]  meta;

   modport source (output dv, dtype, y, u, v, meta);
   modport sink (input dv, dtype, y, u, v, meta);

endinterface

`default_nettype wire

// ==== src/lookup_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lookup_ram #(
   parameter int pixel_width = 8
) (
   input  logic                                di_clk,
   input  logic [video_pkg::lut_addr_width-1:0] addr,
   input  logic                                we,
   input  logic [pixel_width-1:0]              datai,
   output logic [pixel_width-1:0]              datao
);
   import video_pkg::*;

   logic [pixel_width-1:0] mem [2**lut_addr_width];

   always_ff @(posedge di_clk) begin
      if (we) begin
         mem[addr] <= datai;
      end
      datao <= mem[addr]; // read before write on the same address.
   end

endmodule

`default_nettype wire

// ==== src/lookup_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module lookup_map #(
   parameter int pixel_width   = 8,
   parameter int di_data_width = 16
) (
   input  logic   di_clk,
   input  logic   resetb,
   di_bus_if.term bus,
   pixel_if.sink  pix_in,
   pixel_if.source pix_out
);
   import video_pkg::*;

   logic                      enable;
   logic                      host_acc;
   logic                      ctrl_rd;
   logic [lut_addr_width-1:0] ram_addr;
   logic                      ram_we;
   logic [pixel_width-1:0]    ram_q;

   logic                      dv_d1;
   dtype_e                    dtype_d1;
   logic [pixel_width-1:0]    y_d1;
   logic [pixel_width-1:0]    u_d1;
   logic [pixel_width-1:0]    v_d1;
   logic [meta_width-1:0]     meta_d1;

   // the host owns the table address for the whole access.
   assign host_acc = bus.sel && (bus.read_mode || bus.write_mode);
   assign ram_addr = host_acc ? bus.reg_addr[lut_addr_width-1:0]
                              : lut_addr_width'(pix_in.y);
   assign ram_we   = bus.sel && bus.write && !bus.reg_addr[10];

   lookup_ram #(
      .pixel_width(pixel_width)
   ) u_ram (
      .di_clk(di_clk),
      .addr  (ram_addr),
      .we    (ram_we),
      .datai (bus.datai[pixel_width-1:0]),
      .datao (ram_q)
   );

   always_ff @(posedge di_clk or negedge resetb) begin
      if (!resetb) begin
         enable        <= 1'b0;
         ctrl_rd       <= 1'b0;
         bus.read_rdy  <= 1'b0;
         bus.write_rdy <= 1'b0;
         dv_d1         <= 1'b0;
         pix_out.dv    <= 1'b0;
      end else begin
         if (bus.sel && bus.write && bus.reg_addr[10]) begin
            enable <= bus.datai[0];
         end
         if (bus.sel && bus.read_req) begin
            ctrl_rd <= bus.reg_addr[10];
         end
         bus.read_rdy  <= bus.sel && bus.read_req;
         bus.write_rdy <= bus.sel && bus.write;
         dv_d1         <= pix_in.dv;
         pix_out.dv    <= dv_d1;
      end
   end

   // side fields wait one cycle for the table output.
   always_ff @(posedge di_clk) begin
      dtype_d1     <= pix_in.dtype;
      y_d1         <= pix_in.y;
      u_d1         <= pix_in.u;
      v_d1         <= pix_in.v;
      meta_d1      <= pix_in.meta;
      pix_out.dtype <= dtype_d1;
      pix_out.y    <= enable ? ram_q : y_d1;
      pix_out.u    <= u_d1;
      pix_out.v    <= v_d1;
      pix_out.meta <= meta_d1;
   end

   assign bus.datao  = ctrl_rd ? di_data_width'(enable) : di_data_width'(ram_q);
   assign bus.status = status_ok;

endmodule

`default_nettype wire

// ==== src/chroma_offset.sv ====
`timescale 1ns/1ps
`default_nettype none

module chroma_offset #(
   parameter int pixel_width   = 8,
   parameter int di_data_width = 16
) (
   input  logic    di_clk,
   input  logic    resetb,
   di_bus_if.term  bus,
   pixel_if.sink   pix_in,
   pixel_if.source pix_out
);
   import video_pkg::*;

   logic [pixel_width-1:0] u_off;
   logic [pixel_width-1:0] v_off;

   // signed add of two pixel_width values, clamped to the signed range.
   function automatic logic [pixel_width-1:0] sat_add(input logic [pixel_width-1:0] a,
                                                      input logic [pixel_width-1:0] b);
      logic [pixel_width:0] sum;
      sum = {a[pixel_width-1], a} + {b[pixel_width-1], b};
      if (sum[pixel_width] != sum[pixel_width-1]) begin
         sat_add = {sum[pixel_width], {(pixel_width-1){~sum[pixel_width]}}};
      end else begin
         sat_add = sum[pixel_width-1:0];
      end
   endfunction

   always_ff @(posedge di_clk or negedge resetb) begin
      if (!resetb) begin
         u_off         <= '0;
         v_off         <= '0;
         bus.read_rdy  <= 1'b0;
         bus.write_rdy <= 1'b0;
         bus.datao     <= '0;
         pix_out.dv    <= 1'b0;
      end else begin
         if (bus.sel && bus.write && bus.reg_addr == 32'd0) begin
            u_off <= bus.datai[pixel_width-1:0];
         end
         if (bus.sel && bus.write && bus.reg_addr == 32'd1) begin
            v_off <= bus.datai[pixel_width-1:0];
         end
         if (bus.sel && bus.read_req) begin
            case (bus.reg_addr)
               32'd0:   bus.datao <= di_data_width'(u_off);
               32'd1:   bus.datao <= di_data_width'(v_off);
               default: bus.datao <= '0; // unmapped registers read as zero.
            endcase
         end
         bus.read_rdy  <= bus.sel && bus.read_req;
         bus.write_rdy <= bus.sel && bus.write;
         pix_out.dv    <= pix_in.dv;
      end
   end

   always_ff @(posedge di_clk) begin
      pix_out.dtype <= pix_in.dtype;
      pix_out.y     <= pix_in.y;
      pix_out.u     <= sat_add(pix_in.u, u_off);
      pix_out.v     <= sat_add(pix_in.v, v_off);
      pix_out.meta  <= pix_in.meta;
   end

   assign bus.status = status_ok;

endmodule

`default_nettype wire

// ==== src/di_term_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module di_term_decoder #(
   parameter int di_data_width = 16
) (
   input  logic                     di_clk,
   input  logic                     resetb,
   input  video_pkg::term_e         di_term_addr,
   input  logic [31:0]              di_reg_addr,
   input  logic                     di_read_mode,
   input  logic                     di_read_req,
   input  logic                     di_write_mode,
   input  logic                     di_write,
   input  logic [di_data_width-1:0] di_reg_datai,
   output logic                     di_read_rdy,
   output logic [di_data_width-1:0] di_reg_datao,
   output logic                     di_write_rdy,
   output logic [15:0]              di_transfer_status,
   di_bus_if.host                   lut_bus,
   di_bus_if.host                   chroma_bus
);
   import video_pkg::*;

   logic lut_hit;
   logic chroma_hit;
   logic bad_rd_d1;
   logic bad_wr_d1;

   always_comb begin
      lut_hit    = 1'b0;
      chroma_hit = 1'b0;
      case (di_term_addr)
         term_lookup_map:    lut_hit    = 1'b1;
         term_chroma_offset: chroma_hit = 1'b1;
         default: ;
      endcase
   end

   assign lut_bus.sel        = lut_hit;
   assign lut_bus.reg_addr   = di_reg_addr;
   assign lut_bus.read_mode  = di_read_mode;
   assign lut_bus.read_req   = di_read_req;
   assign lut_bus.write_mode = di_write_mode;
   assign lut_bus.write      = di_write;
   assign lut_bus.datai      = di_reg_datai;

   assign chroma_bus.sel        = chroma_hit;
   assign chroma_bus.reg_addr   = di_reg_addr;
   assign chroma_bus.read_mode  = di_read_mode;
   assign chroma_bus.read_req   = di_read_req;
   assign chroma_bus.write_mode = di_write_mode;
   assign chroma_bus.write      = di_write;
   assign chroma_bus.datai      = di_reg_datai;

   always_ff @(posedge di_clk or negedge resetb) begin
      if (!resetb) begin
         bad_rd_d1          <= 1'b0;
         bad_wr_d1          <= 1'b0;
         di_read_rdy        <= 1'b0;
         di_write_rdy       <= 1'b0;
         di_reg_datao       <= '0;
         di_transfer_status <= status_ok;
      end else begin
         // unknown terminals get the same two cycle latency as real ones.
         bad_rd_d1    <= !lut_hit && !chroma_hit && di_read_req;
         bad_wr_d1    <= !lut_hit && !chroma_hit && di_write;
         di_read_rdy  <= lut_bus.read_rdy || chroma_bus.read_rdy || bad_rd_d1;
         di_write_rdy <= lut_bus.write_rdy || chroma_bus.write_rdy || bad_wr_d1;
         if (lut_bus.read_rdy || lut_bus.write_rdy) begin
            di_reg_datao       <= lut_bus.read_rdy ? lut_bus.datao : '0;
            di_transfer_status <= lut_bus.status;
         end else if (chroma_bus.read_rdy || chroma_bus.write_rdy) begin
            di_reg_datao       <= chroma_bus.read_rdy ? chroma_bus.datao : '0;
            di_transfer_status <= chroma_bus.status;
         end else if (bad_rd_d1 || bad_wr_d1) begin
            di_reg_datao       <= '0;
            di_transfer_status <= status_bad_term;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/video_pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_pipe_top #(
   parameter int pixel_width   = 8,
   parameter int di_data_width = 16
) (
   input  logic                              di_clk,
   input  logic                              resetb,
   input  video_pkg::term_e                  di_term_addr,
   input  logic [31:0]                       di_reg_addr,
   input  logic                              di_read_mode,
   input  logic                              di_read_req,
   input  logic                              di_write_mode,
   input  logic                              di_write,
   input  logic [di_data_width-1:0]          di_reg_datai,
   output logic                              di_read_rdy,
   output logic [di_data_width-1:0]          di_reg_datao,
   output logic                              di_write_rdy,
   output logic [15:0]                       di_transfer_status,
   input  logic                              dvi,
   input  video_pkg::dtype_e                 dtypei,
   input  logic        [pixel_width-1:0]     yi,
   input  logic signed [pixel_width-1:0]     ui,
   input  logic signed [pixel_width-1:0]     vi,
   input  logic [video_pkg::meta_width-1:0]  meta_datai,
   output logic                              dvo,
   output video_pkg::dtype_e                 dtypeo,
   output logic        [pixel_width-1:0]     yo,
   output logic signed [pixel_width-1:0]     uo,
   output logic signed [pixel_width-1:0]     vo,
   output logic [video_pkg::meta_width-1:0]  meta_datao
);

   di_bus_if #(.di_data_width(di_data_width)) lut_bus ();
   di_bus_if #(.di_data_width(di_data_width)) chroma_bus ();
   pixel_if #(.pixel_width(pixel_width)) pix_in ();
   pixel_if #(.pixel_width(pixel_width)) pix_mid ();
   pixel_if #(.pixel_width(pixel_width)) pix_out ();

   assign pix_in.dv    = dvi;
   assign pix_in.dtype = dtypei;
   assign pix_in.y     = yi;
   assign pix_in.u     = ui;
   assign pix_in.v     = vi;
   assign pix_in.meta  = meta_datai;

   di_term_decoder #(
      .di_data_width(di_data_width)
   ) u_decoder (
      .di_clk            (di_clk),
      .resetb            (resetb),
      .di_term_addr      (di_term_addr),
      .di_reg_addr       (di_reg_addr),
      .di_read_mode      (di_read_mode),
      .di_read_req       (di_read_req),
      .di_write_mode     (di_write_mode),
      .di_write          (di_write),
      .di_reg_datai      (di_reg_datai),
      .di_read_rdy       (di_read_rdy),
      .di_reg_datao      (di_reg_datao),
      .di_write_rdy      (di_write_rdy),
      .di_transfer_status(di_transfer_status),
      .lut_bus           (lut_bus.host),
      .chroma_bus        (chroma_bus.host)
   );

   lookup_map #(
      .pixel_width  (pixel_width),
      .di_data_width(di_data_width)
   ) u_lookup_map (
      .di_clk (di_clk),
      .resetb (resetb),
      .bus    (lut_bus.term),
      .pix_in (pix_in.sink),
      .pix_out(pix_mid.source)
   );

   chroma_offset #(
      .pixel_width  (pixel_width),
      .di_data_width(di_data_width)
   ) u_chroma_offset (
      .di_clk (di_clk),
      .resetb (resetb),
      .bus    (chroma_bus.term),
      .pix_in (pix_mid.sink),
      .pix_out(pix_out.source)
   );

   assign dvo        = pix_out.dv;
   assign dtypeo     = pix_out.dtype;
   assign yo         = pix_out.y;
   assign uo         = pix_out.u;
   assign vo         = pix_out.v;
   assign meta_datao = pix_out.meta;

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 3
) (
   output logic di_clk,
   output logic resetb
);

   initial begin
      di_clk = 1'b0;
      forever #(period_ns / 2) di_clk = ~di_clk;
   end

   initial begin
      resetb = 1'b0;
      repeat (reset_cycles) @(posedge di_clk);
      #2 resetb = 1'b1; // release just after the edge.
   end

endmodule

`default_nettype wire

// ==== tests/tb_video_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_video_pipe;
   import video_pkg::*;

   localparam int pixel_width   = 8;
   localparam int di_data_width = 16;
   localparam int drive_delay   = 2;
   localparam int ready_timeout = 20;
   localparam int drain_timeout = 50;

   logic                          di_clk;
   logic                          resetb;
   term_e                         di_term_addr;
   logic [31:0]                   di_reg_addr;
   logic                          di_read_mode;
   logic                          di_read_req;
   logic                          di_write_mode;
   logic                          di_write;
   logic [di_data_width-1:0]      di_reg_datai;
   logic                          di_read_rdy;
   logic [di_data_width-1:0]      di_reg_datao;
   logic                          di_write_rdy;
   logic [15:0]                   di_transfer_status;
   logic                          dvi;
   dtype_e                        dtypei;
   logic        [pixel_width-1:0] yi;
   logic signed [pixel_width-1:0] ui;
   logic signed [pixel_width-1:0] vi;
   logic [meta_width-1:0]         meta_datai;
   logic                          dvo;
   dtype_e                        dtypeo;
   logic        [pixel_width-1:0] yo;
   logic signed [pixel_width-1:0] uo;
   logic signed [pixel_width-1:0] vo;
   logic [meta_width-1:0]         meta_datao;

   logic [47:0] exp_q [$]; // {dtype, meta, y, u, v} of each beat still in the pipe.
   logic [47:0] beat;
   int          error_count   = 0;
   int          timeout_count = 0;
   int          in_beats      = 0;
   int          out_beats     = 0;

   tb_clock_gen #(.period_ns(40), .reset_cycles(3)) u_clock_gen (
      .di_clk(di_clk),
      .resetb(resetb)
   );

   video_pipe_top #(
      .pixel_width  (pixel_width),
      .di_data_width(di_data_width)
   ) uut (
      .di_clk            (di_clk),
      .resetb            (resetb),
      .di_term_addr      (di_term_addr),
      .di_reg_addr       (di_reg_addr),
      .di_read_mode      (di_read_mode),
      .di_read_req       (di_read_req),
      .di_write_mode     (di_write_mode),
      .di_write          (di_write),
      .di_reg_datai      (di_reg_datai),
      .di_read_rdy       (di_read_rdy),
      .di_reg_datao      (di_reg_datao),
      .di_write_rdy      (di_write_rdy),
      .di_transfer_status(di_transfer_status),
      .dvi               (dvi),
      .dtypei            (dtypei),
      .yi                (yi),
      .ui                (ui),
      .vi                (vi),
      .meta_datai        (meta_datai),
      .dvo               (dvo),
      .dtypeo            (dtypeo),
      .yo                (yo),
      .uo                (uo),
      .vo                (vo),
      .meta_datao        (meta_datao)
   );

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         error_count = error_count + 1;
         $display("[ERROR] %t %s: got %h, expected %h", $realtime, what, got, expected);
      end
   endtask

   task automatic next_cycle();
      @(posedge di_clk);
      #drive_delay;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         next_cycle();
         dvi = 1'b0;
      end
   endtask

   task automatic wait_for_ready(input string what, input bit is_read, output bit seen);
      int cycles;
      seen   = 1'b0;
      cycles = 0;
      while (!seen && cycles < ready_timeout) begin
         @(negedge di_clk);
         seen   = is_read ? di_read_rdy : di_write_rdy;
         cycles = cycles + 1;
      end
      if (!seen) begin
         timeout_count = timeout_count + 1;
         $display("Timeout at %t: the %s ready never arrived.", $realtime, what);
      end
   endtask

   task automatic reg_write(input logic [15:0] term, input logic [31:0] addr,
                            input logic [15:0] data, input logic [15:0] exp_status);
      bit seen;
      next_cycle();
      dvi           = 1'b0;
      di_term_addr  = term_e'(term);
      di_reg_addr   = addr;
      di_reg_datai  = data;
      di_write_mode = 1'b1;
      di_write      = 1'b1;
      next_cycle();
      di_write = 1'b0;
      wait_for_ready("write", 1'b0, seen);
      if (seen) begin
         check_value($sformatf("write status term %h reg %h", term, addr),
                     di_transfer_status, exp_status);
      end
      next_cycle();
      di_write_mode = 1'b0;
   endtask

   task automatic reg_read(input logic [15:0] term, input logic [31:0] addr,
                           input logic [15:0] exp_data, input logic [15:0] exp_status);
      bit seen;
      next_cycle();
      dvi          = 1'b0;
      di_term_addr = term_e'(term);
      di_reg_addr  = addr;
      di_read_mode = 1'b1;
      di_read_req  = 1'b1;
      next_cycle();
      di_read_req = 1'b0;
      wait_for_ready("read", 1'b1, seen);
      if (seen) begin
         check_value($sformatf("read data term %h reg %h", term, addr),
                     di_reg_datao, exp_data);
         check_value($sformatf("read status term %h reg %h", term, addr),
                     di_transfer_status, exp_status);
      end
      next_cycle();
      di_read_mode = 1'b0;
   endtask

   task automatic send_pixel(input logic [2:0] dtype, input logic [7:0] y, input logic [7:0] u,
                             input logic [7:0] v, input logic [15:0] meta,
                             input logic [7:0] exp_y, input logic [7:0] exp_u,
                             input logic [7:0] exp_v);
      next_cycle();
      dvi        = 1'b1;
      dtypei     = dtype_e'(dtype);
      yi         = y;
      ui         = u;
      vi         = v;
      meta_datai = meta;
      exp_q.push_back({5'd0, dtype, meta, exp_y, exp_u, exp_v});
      in_beats = in_beats + 1;
   endtask

   task automatic drain_outputs();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0 && cycles < drain_timeout) begin
         @(negedge di_clk);
         cycles = cycles + 1;
      end
      if (exp_q.size() != 0) begin
         timeout_count = timeout_count + 1;
         $display("Timeout at %t: %0d pixels never came out.", $realtime, exp_q.size());
      end
   endtask

   task automatic run_trace();
      int               fd;
      int               n;
      bit               done;
      logic [7:0]       kind;
      logic [8*200-1:0] skip_buf;
      logic [31:0]      f1, f2, f3, f4, f5, f6, f7, f8;
      fd = $fopen("tests/video_pipe_trace.txt", "r");
      if (fd == 0) begin
         error_count = error_count + 1;
         $display("Could not open the trace file tests/video_pipe_trace.txt.");
      end else begin
         done = 1'b0;
         while (!done) begin
            n = $fscanf(fd, " %c", kind);
            if (n != 1) begin
               done = 1'b1;
            end else if (kind == "#") begin
               n = $fgets(skip_buf, fd);
            end else if (kind == "W") begin
               n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
               reg_write(f1[15:0], f2, f3[15:0], f4[15:0]);
            end else if (kind == "R") begin
               n = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
               reg_read(f1[15:0], f2, f3[15:0], f4[15:0]);
            end else if (kind == "P") begin
               n = $fscanf(fd, "%h %h %h %h %h %h %h %h", f1, f2, f3, f4, f5, f6, f7, f8);
               send_pixel(f1[2:0], f2[7:0], f3[7:0], f4[7:0], f5[15:0],
                          f6[7:0], f7[7:0], f8[7:0]);
            end else if (kind == "I") begin
               n = $fscanf(fd, "%h", f1);
               idle_cycles(f1);
            end else begin
               error_count = error_count + 1;
               $display("The trace holds an unknown record kind '%c'.", kind);
               done = 1'b1;
            end
         end
         $fclose(fd);
      end
   endtask

   // outputs settle after the rising edge, so they are compared on the falling one.
   always @(negedge di_clk) begin
      if (resetb === 1'b1 && dvo === 1'b1) begin
         out_beats = out_beats + 1;
         if (exp_q.size() == 0) begin
            error_count = error_count + 1;
            $display("An output beat came at %t with no input pixel left to match.", $realtime);
         end else begin
            beat = exp_q.pop_front();
            check_value("dtypeo", {29'd0, dtypeo}, {29'd0, beat[42:40]});
            check_value("meta_datao", {16'd0, meta_datao}, {16'd0, beat[39:24]});
            check_value("yo", {24'd0, yo}, {24'd0, beat[23:16]});
            check_value("uo", {24'd0, uo}, {24'd0, beat[15:8]});
            check_value("vo", {24'd0, vo}, {24'd0, beat[7:0]});
         end
      end
   end

   initial begin
      int cycles;
      $timeformat(-9, 0, " ns", 8);
      di_term_addr  = term_lookup_map;
      di_reg_addr   = '0;
      di_read_mode  = 1'b0;
      di_read_req   = 1'b0;
      di_write_mode = 1'b0;
      di_write      = 1'b0;
      di_reg_datai  = '0;
      dvi           = 1'b0;
      dtypei        = dt_frame_start;
      yi            = '0;
      ui            = '0;
      vi            = '0;
      meta_datai    = '0;
      cycles = 0;
      while (resetb !== 1'b1 && cycles < 10) begin
         @(posedge di_clk);
         cycles = cycles + 1;
      end
      if (resetb !== 1'b1) begin
         timeout_count = timeout_count + 1;
         $display("Reset was never released.");
      end
      @(negedge di_clk);
      check_value("dvo after reset", {31'd0, dvo}, 32'd0);
      check_value("read ready after reset", {31'd0, di_read_rdy}, 32'd0);
      check_value("write ready after reset", {31'd0, di_write_rdy}, 32'd0);
      run_trace();
      idle_cycles(1);
      drain_outputs();
      idle_cycles(4); // a stray extra beat would show up here.
      check_value("output beat count", out_beats, in_beats);
      $display("Errors: %0d, timeouts: %0d, beats in: %0d, beats out: %0d",
               error_count, timeout_count, in_beats, out_beats);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
src/video_pkg.sv
src/di_bus_if.sv
src/pixel_if.sv
src/lookup_ram.sv
src/lookup_map.sv
src/chroma_offset.sv
src/di_term_decoder.sv
src/video_pipe_top.sv
tests/tb_clock_gen.sv
tests/tb_video_pipe.sv

// ==== tests/video_pipe_trace.txt ====
# W term reg_addr data exp_status | R term reg_addr exp_data exp_status | I idle_cycles
# P dtype y u v meta exp_y exp_u exp_v, all fields in hex
R 0001 00000400 0000 0000
W 0001 00000010 005a 0000
W 0001 00000020 00c3 0000
W 0001 00000080 0001 0000
W 0001 000000ff 0033 0000
W 0001 000003ff 007e 0000
R 0001 00000010 005a 0000
R 0001 00000020 00c3 0000
R 0001 00000080 0001 0000
R 0001 000000ff 0033 0000
R 0001 000003ff 007e 0000
# table disabled, offsets zero
P 0 10 05 fb 1000 10 05 fb
P 1 20 7f 80 1001 20 7f 80
P 2 80 00 01 1002 80 00 01
P 3 ff 12 34 1003 ff 12 34
I 4
P 4 33 44 55 1004 33 44 55
I 5
W 0001 00000400 0001 0000
R 0001 00000400 0001 0000
P 0 10 11 22 2000 5a 11 22
P 2 20 33 44 2001 c3 33 44
I 2
P 2 80 55 66 2002 01 55 66
I 1
P 4 ff 77 88 2003 33 77 88
I 5
# u offset +16, v offset -16
W 0002 00000000 0010 0000
W 0002 00000001 00f0 0000
R 0002 00000000 0010 0000
R 0002 00000001 00f0 0000
R 0002 00000005 0000 0000
P 1 10 20 20 3000 5a 30 10
P 2 20 7a 85 3001 c3 7f 80
P 2 80 6f 90 3002 01 7f 80
P 3 ff f0 0f 3003 33 00 ff
I 5
# unknown terminal must not touch any register
W 0007 00000400 0000 ffff
R 0007 00000000 0000 ffff
R 0001 00000400 0001 0000
R 0002 00000000 0010 0000
R 0001 00000010 005a 0000
W 0001 00000400 0000 0000
W 0002 00000000 0080 0000
W 0002 00000001 007f 0000
P 2 10 85 10 4000 10 80 7f
P 2 20 7f 80 4001 20 ff ff
I 6
